/* Makefile */
VERILATOR  ?= verilator
TOP        ?= ex_tb
FLIST      ?= verilog.f
BUILD      ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps -Wall

SRCS := $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

/* hw/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit import rv_pkg::*; (
    input  alu_class_e alu_class_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7_b30_i,
    input  word_t      a_i,
    input  word_t      b_i,
    output word_t      result_o
);

    alu_op_e    op;
    logic [4:0] shamt;
    logic       is_reg;

    assign shamt  = b_i[4:0];
    assign is_reg = alu_class_i == CLS_REG_OP;

    always_comb begin
        op = ALU_ADD;
        case (alu_class_i)
            CLS_ADD_ONLY:   op = ALU_ADD;
            CLS_BRANCH_SUB: op = ALU_SUB;
            default: begin
                case (funct3_i)
                    // bit 30 selects sub only for register ops
                    3'b000:  op = (is_reg && funct7_b30_i) ? ALU_SUB : ALU_ADD;
                    3'b001:  op = ALU_SLL;
                    3'b010:  op = ALU_SLT;
                    3'b011:  op = ALU_SLTU;
                    3'b100:  op = ALU_XOR;
                    3'b101:  op = funct7_b30_i ? ALU_SRA : ALU_SRL;
                    3'b110:  op = ALU_OR;
                    default: op = ALU_AND;
                endcase
            end
        endcase
    end

    always_comb begin
        case (op)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLTU:   result_o = word_t'(a_i < b_i);
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = word_t'($signed(a_i) >>> shamt);
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit import rv_pkg::*; (
    input  logic [2:0] funct3_i,
    input  logic       branch_i,
    input  jump_e      jump_i,
    input  word_t      a_i,
    input  word_t      b_i,
    input  word_t      pc_i,
    input  word_t      imm_i,
    output logic       taken_o,
    output word_t      target_o
);

    logic  cond;
    word_t jalr_sum;

    always_comb begin
        case (funct3_i)
            3'b000:  cond = a_i == b_i;
            3'b001:  cond = a_i != b_i;
            3'b100:  cond = $signed(a_i) < $signed(b_i);
            3'b101:  cond = $signed(a_i) >= $signed(b_i);
            3'b110:  cond = a_i < b_i;
            3'b111:  cond = a_i >= b_i;
            default: cond = 1'b0;
        endcase
    end

    assign taken_o = (jump_i != JMP_NONE) || (branch_i && cond);

    // jalr drops bit 0 of the sum
    assign jalr_sum = a_i + imm_i;
    assign target_o = (jump_i == JMP_JALR) ? (jalr_sum & ~word_t'(1)) : pc_i + imm_i;

endmodule

`default_nettype wire

/* hw/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module data_mem import rv_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      req_valid_i,
    input  mem_req_t  req_i,
    output logic      ld_valid_o,
    output reg_addr_t ld_rd_o,
    output word_t     ld_data_o
);

    localparam int idx_w = $clog2(`RV_DMEM_WORDS);

    word_t            mem [`RV_DMEM_WORDS];
    logic [idx_w-1:0] idx;
    word_t            rd_word_q;
    logic [2:0]       funct3_q;
    logic [1:0]       boff_q;
    word_t            shifted;

    // upper address bits wrap
    assign idx = req_i.waddr[idx_w-1:0];

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            for (int i = 0; i < 4; i++) begin
                if (req_i.be[i]) begin
                    mem[idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        rd_word_q <= mem[idx];
        funct3_q  <= req_i.funct3;
        boff_q    <= req_i.boff;
        ld_rd_o   <= req_i.rd;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ld_valid_o <= 1'b0;
        end else begin
            ld_valid_o <= req_valid_i && req_i.load;
        end
    end

    assign shifted = rd_word_q >> {boff_q, 3'b000};

    always_comb begin
        case (funct3_q)
            3'b000:  ld_data_o = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  ld_data_o = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  ld_data_o = {24'b0, shifted[7:0]};
            3'b101:  ld_data_o = {16'b0, shifted[15:0]};
            default: ld_data_o = rd_word_q;
        endcase
    end

endmodule

`default_nettype wire

/* hw/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage import rv_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       req_valid_i,
    input  ex_req_t    req_i,
    input  fwd_t       fwd_i,
    output logic       res_valid_o,
    output ex_res_t    res_o,
    output logic       mem_valid_o,
    output mem_op_e    mem_op_o,
    output word_t      mem_addr_o,
    output word_t      mem_wdata_o,
    output logic [2:0] mem_funct3_o,
    output reg_addr_t  mem_rd_o
);

    logic    fwd_rs1;
    logic    fwd_rs2;
    word_t   rs1_val;
    word_t   rs2_val;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_result;
    word_t   link;
    word_t   target;
    logic    taken;
    word_t   csr_data;
    ex_res_t res_d;

    // write-back forwarding, x0 never forwarded
    assign fwd_rs1 = fwd_i.valid && (fwd_i.rd == req_i.rs1_addr) && (req_i.rs1_addr != '0);
    assign fwd_rs2 = fwd_i.valid && (fwd_i.rd == req_i.rs2_addr) && (req_i.rs2_addr != '0);
    assign rs1_val = fwd_rs1 ? fwd_i.data : req_i.rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_i.data : req_i.rs2_data;

    always_comb begin
        case (req_i.op_src)
            SRC_PC:   op_a = req_i.pc;
            SRC_ZERO: op_a = '0;
            default:  op_a = rs1_val;
        endcase
    end

    assign op_b = req_i.use_imm ? req_i.imm : rs2_val;

    alu_unit u_alu (
        .alu_class_i  (req_i.alu_class),
        .funct3_i     (req_i.funct3),
        .funct7_b30_i (req_i.funct7_b30),
        .a_i          (op_a),
        .b_i          (op_b),
        .result_o     (alu_result)
    );

    branch_unit u_branch (
        .funct3_i (req_i.funct3),
        .branch_i (req_i.branch),
        .jump_i   (req_i.jump),
        .a_i      (rs1_val),
        .b_i      (rs2_val),
        .pc_i     (req_i.pc),
        .imm_i    (req_i.imm),
        .taken_o  (taken),
        .target_o (target)
    );

    assign link = req_i.pc + word_t'(4);

    // csrrw takes rs1, csrrwi the immediate
    always_comb begin
        case (req_i.funct3)
            3'b001:  csr_data = rs1_val;
            3'b101:  csr_data = req_i.imm;
            default: csr_data = '0;
        endcase
    end

    always_comb begin
        res_d.result   = (req_i.jump != JMP_NONE) ? link : alu_result;
        res_d.rd       = req_i.rd_addr;
        res_d.wb_en    = req_i.wb_en;
        res_d.taken    = taken;
        res_d.target   = target;
        res_d.csr_we   = req_i.csr_we;
        res_d.csr_data = csr_data;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            res_valid_o <= 1'b0;
            mem_valid_o <= 1'b0;
        end else begin
            res_valid_o <= req_valid_i;
            mem_valid_o <= req_valid_i && (req_i.mem_op != MEM_NONE);
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            res_o        <= res_d;
            mem_op_o     <= req_i.mem_op;
            mem_addr_o   <= alu_result;
            mem_wdata_o  <= rs2_val;
            mem_funct3_o <= req_i.funct3;
            mem_rd_o     <= req_i.rd_addr;
        end
    end

endmodule

`default_nettype wire

/* hw/ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top import rv_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      req_valid_i,
    input  ex_req_t   req_i,
    input  fwd_t      fwd_i,
    output logic      res_valid_o,
    output ex_res_t   res_o,
    output logic      ld_valid_o,
    output reg_addr_t ld_rd_o,
    output word_t     ld_data_o,
    output mmio_wr_t  mmio_o
);

    logic       mem_valid;
    mem_op_e    mem_op;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic [2:0] mem_funct3;
    reg_addr_t  mem_rd;
    logic       dmem_req_valid;
    mem_req_t   dmem_req;

    ex_stage u_ex (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .fwd_i        (fwd_i),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o),
        .mem_valid_o  (mem_valid),
        .mem_op_o     (mem_op),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_funct3_o (mem_funct3),
        .mem_rd_o     (mem_rd)
    );

    store_align u_align (
        .mem_valid_i      (mem_valid),
        .mem_op_i         (mem_op),
        .mem_addr_i       (mem_addr),
        .mem_wdata_i      (mem_wdata),
        .mem_funct3_i     (mem_funct3),
        .mem_rd_i         (mem_rd),
        .dmem_req_valid_o (dmem_req_valid),
        .dmem_req_o       (dmem_req),
        .mmio_o           (mmio_o)
    );

    data_mem u_dmem (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (dmem_req_valid),
        .req_i       (dmem_req),
        .ld_valid_o  (ld_valid_o),
        .ld_rd_o     (ld_rd_o),
        .ld_data_o   (ld_data_o)
    );

endmodule

`default_nettype wire

/* hw/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data word width in bits
`define RV_XLEN 32

// data memory depth in words
`define RV_DMEM_WORDS 256

// peripheral window, 32 bytes from here
`define RV_MMIO_BASE 32'h8000_0000

`endif

/* hw/rv_pkg.sv */
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [1:0] {
        CLS_ADD_ONLY,
        CLS_BRANCH_SUB,
        CLS_REG_OP,
        CLS_IMM_OP
    } alu_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG,
        SRC_PC,
        SRC_ZERO
    } op_src_e;

    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_JAL,
        JMP_JALR
    } jump_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // decoded instruction into execute
    typedef struct packed {
        word_t      pc;
        reg_addr_t  rs1_addr;
        reg_addr_t  rs2_addr;
        word_t      rs1_data;
        word_t      rs2_data;
        reg_addr_t  rd_addr;
        word_t      imm;
        logic [2:0] funct3;
        logic       funct7_b30;
        alu_class_e alu_class;
        op_src_e    op_src;
        logic       use_imm;
        jump_e      jump;
        logic       branch;
        mem_op_e    mem_op;
        logic       wb_en;
        logic       csr_we;
    } ex_req_t;

    // instruction currently in write-back
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        word_t     result;
        reg_addr_t rd;
        logic      wb_en;
        logic      taken;
        word_t     target;
        logic      csr_we;
        word_t     csr_data;
    } ex_res_t;

    typedef struct packed {
        logic [`RV_XLEN-3:0] waddr;
        logic [1:0]          boff;
        word_t               wdata;
        logic [3:0]          be;
        logic                load;
        logic [2:0]          funct3;
        reg_addr_t           rd;
    } mem_req_t;

    typedef struct packed {
        logic [4:0] offset;
        word_t      data;
        logic [3:0] be;
        logic       valid;
    } mmio_wr_t;

endpackage

`default_nettype wire

/* hw/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module store_align import rv_pkg::*; (
    input  logic       mem_valid_i,
    input  mem_op_e    mem_op_i,
    input  word_t      mem_addr_i,
    input  word_t      mem_wdata_i,
    input  logic [2:0] mem_funct3_i,
    input  reg_addr_t  mem_rd_i,
    output logic       dmem_req_valid_o,
    output mem_req_t   dmem_req_o,
    output mmio_wr_t   mmio_o
);

    localparam word_t mmio_base = `RV_MMIO_BASE;

    logic       in_window;
    logic       is_store;
    logic [1:0] lane;
    logic [3:0] mask;
    logic [3:0] be;
    word_t      wdata;

    assign in_window = mem_addr_i[31:5] == mmio_base[31:5];
    assign is_store  = mem_op_i == MEM_STORE;

    // sh keeps to the aligned half, sw to lane 0
    always_comb begin
        case (mem_funct3_i[1:0])
            2'b00: begin
                lane = mem_addr_i[1:0];
                mask = 4'b0001;
            end
            2'b01: begin
                lane = {mem_addr_i[1], 1'b0};
                mask = 4'b0011;
            end
            default: begin
                lane = 2'b00;
                mask = 4'b1111;
            end
        endcase
    end

    assign be    = is_store ? mask << lane : 4'b0000;
    assign wdata = mem_wdata_i << {lane, 3'b000};

    // loads from the window are dropped, no peripheral read path here
    assign dmem_req_valid_o = mem_valid_i && !in_window && (mem_op_i != MEM_NONE);

    assign dmem_req_o.waddr  = mem_addr_i[31:2];
    assign dmem_req_o.boff   = mem_addr_i[1:0];
    assign dmem_req_o.wdata  = wdata;
    assign dmem_req_o.be     = be;
    assign dmem_req_o.load   = mem_op_i == MEM_LOAD;
    assign dmem_req_o.funct3 = mem_funct3_i;
    assign dmem_req_o.rd     = mem_rd_i;

    assign mmio_o.offset = mem_addr_i[4:0];
    assign mmio_o.data   = wdata;
    assign mmio_o.be     = be;
    assign mmio_o.valid  = mem_valid_i && is_store && in_window;

endmodule

`default_nettype wire

/* sim/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset spans two rising edges, released on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/ex_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_chk import rv_pkg::*; (
    input logic     clk_i,
    input logic     reset_i,
    input logic     req_valid_i,
    input ex_req_t  req_i,
    input logic     res_valid_i,
    input logic     ld_valid_i,
    input mmio_wr_t mmio_i,
    input logic     dmem_req_valid_i,
    input mem_req_t dmem_req_i
);

    logic load_issued;
    logic store_issued;

    assign load_issued  = req_valid_i && (req_i.mem_op == MEM_LOAD);
    assign store_issued = req_valid_i && (req_i.mem_op == MEM_STORE);

    ld_needs_load: assert property (
        @(posedge clk_i) disable iff (reset_i)
        ld_valid_i |-> $past(load_issued, 2)
    ) else $error("load data returned without a load two cycles earlier");

    // a store goes to exactly one of the window and memory
    one_write_target: assert property (
        @(posedge clk_i) disable iff (reset_i)
        store_issued |=>
            (mmio_i.valid != (dmem_req_valid_i && (dmem_req_i.be != 4'b0000)))
    ) else $error("store went to both or neither of the peripheral window and memory");

    quiet_in_reset: assert property (
        @(posedge clk_i)
        reset_i |=> !res_valid_i && !ld_valid_i && !mmio_i.valid
    ) else $error("output valid high while in reset");

endmodule

`default_nettype wire

/* sim/ex_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_tb import rv_pkg::*; ();

    localparam int clk_period = 20;
    localparam int n_reqs     = 32 + 6 + 20 + 31 + 4 + 11;
    // loads and window stores hold two cycles each
    localparam int timeout_ns = 2 * clk_period * n_reqs + 1000;

    logic      clk;
    logic      reset;
    logic      req_valid;
    ex_req_t   req;
    fwd_t      fwd;
    logic      res_valid;
    ex_res_t   res;
    logic      ld_valid;
    reg_addr_t ld_rd;
    word_t     ld_data;
    mmio_wr_t  mmio;

    int         n_checks;
    int         n_errs;
    int         test_errs;
    logic [7:0] mem_model [1024];

    clk_gen u_clk (
        .clk_o   (clk),
        .reset_o (reset)
    );

    ex_top DUT (
        .clk_i       (clk),
        .reset_i     (reset),
        .req_valid_i (req_valid),
        .req_i       (req),
        .fwd_i       (fwd),
        .res_valid_o (res_valid),
        .res_o       (res),
        .ld_valid_o  (ld_valid),
        .ld_rd_o     (ld_rd),
        .ld_data_o   (ld_data),
        .mmio_o      (mmio)
    );

    bind ex_top ex_chk u_chk (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .res_valid_i      (res_valid_o),
        .ld_valid_i       (ld_valid_o),
        .mmio_i           (mmio_o),
        .dmem_req_valid_i (dmem_req_valid),
        .dmem_req_i       (dmem_req)
    );

    task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
        n_checks++;
        if (act !== exp) begin
            n_errs++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, n_errs - test_errs);
    endtask

    // one strobe, returns on the falling edge after capture
    task automatic send(input ex_req_t r, input fwd_t f);
        req       = r;
        fwd       = f;
        req_valid = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        fwd       = '0;
    endtask

    function automatic word_t alu_model(input logic is_reg, input logic [2:0] f3,
                                        input logic b30, input word_t a, input word_t b);
        logic [4:0] s;
        s = b[4:0];
        case (f3)
            3'b000:  return (is_reg && b30) ? a - b : a + b;
            3'b001:  return a << s;
            3'b010:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return (a >> s) | ((b30 && a[31]) ? ~(32'hFFFF_FFFF >> s) : 32'h0);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        logic lt;
        lt = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return lt;
            3'b101:  return !lt;
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t load_model(input word_t addr, input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       w;
        b = mem_model[addr[9:0]];
        h = {mem_model[{addr[9:1], 1'b1}], mem_model[{addr[9:1], 1'b0}]};
        w = {mem_model[{addr[9:2], 2'd3}], mem_model[{addr[9:2], 2'd2}],
             mem_model[{addr[9:2], 2'd1}], mem_model[{addr[9:2], 2'd0}]};
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b100:  return {24'b0, b};
            3'b101:  return {16'b0, h};
            default: return w;
        endcase
    endfunction

    // address from rs1 plus a positive or negative offset
    function automatic ex_req_t mem_req(input word_t addr, input logic [2:0] f3);
        ex_req_t r;
        r          = '0;
        r.funct3   = f3;
        r.use_imm  = 1'b1;
        r.imm      = addr[2] ? 32'hFFFF_FFF8 : 32'h0000_0010;
        r.rs1_addr = 5'd8;
        r.rs1_data = addr - r.imm;
        r.rs2_addr = 5'd9;
        return r;
    endfunction

    task automatic do_store(input word_t addr, input logic [2:0] f3, input word_t data,
                            input fwd_t f);
        ex_req_t r;
        word_t   wd;
        r          = mem_req(addr, f3);
        r.mem_op   = MEM_STORE;
        r.rs2_data = data;
        wd = (f.valid && f.rd == r.rs2_addr) ? f.data : data;
        send(r, f);
        check_eq("res_valid_o", 32'(res_valid), 32'd1);
        check_eq("mmio_o.valid", 32'(mmio.valid), 32'd0);
        case (f3[1:0])
            2'b00: mem_model[addr[9:0]] = wd[7:0];
            2'b01: begin
                mem_model[{addr[9:1], 1'b0}] = wd[7:0];
                mem_model[{addr[9:1], 1'b1}] = wd[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    mem_model[{addr[9:2], 2'(i)}] = wd[8*i +: 8];
                end
            end
        endcase
    endtask

    task automatic do_load(input word_t addr, input logic [2:0] f3);
        ex_req_t r;
        r         = mem_req(addr, f3);
        r.mem_op  = MEM_LOAD;
        r.rd_addr = 5'd12;
        r.wb_en   = 1'b1;
        send(r, '0);
        check_eq("ld_valid_o", 32'(ld_valid), 32'd0);
        @(negedge clk);
        check_eq("ld_valid_o", 32'(ld_valid), 32'd1);
        check_eq("ld_rd_o", 32'(ld_rd), 32'd12);
        check_eq("ld_data_o", ld_data, load_model(addr, f3));
    endtask

    task automatic mmio_store(input word_t addr, input logic [2:0] f3, input word_t data,
                              input logic [3:0] be, input word_t exp_data);
        ex_req_t r;
        r          = mem_req(addr, f3);
        r.mem_op   = MEM_STORE;
        r.rs2_data = data;
        send(r, '0);
        check_eq("mmio_o.valid", 32'(mmio.valid), 32'd1);
        check_eq("mmio_o.offset", 32'(mmio.offset), 32'(addr[4:0]));
        check_eq("mmio_o.data", mmio.data, exp_data);
        check_eq("mmio_o.be", 32'(mmio.be), 32'(be));
        @(negedge clk);
        check_eq("mmio_o.valid", 32'(mmio.valid), 32'd0);
    endtask

    task automatic test_alu();
        ex_req_t r;
        word_t   a;
        word_t   b;
        test_errs = n_errs;
        for (int c = 0; c < 2; c++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int b30 = 0; b30 < 2; b30++) begin
                    a            = $urandom();
                    b            = $urandom();
                    r            = '0;
                    r.alu_class  = (c == 0) ? CLS_REG_OP : CLS_IMM_OP;
                    r.funct3     = 3'(f3);
                    r.funct7_b30 = 1'(b30);
                    r.rs1_addr   = 5'd1;
                    r.rs1_data   = a;
                    r.rs2_addr   = 5'd2;
                    r.rs2_data   = (c == 0) ? b : ~b;
                    r.use_imm    = (c != 0);
                    r.imm        = b;
                    r.rd_addr    = 5'd3;
                    r.wb_en      = 1'b1;
                    send(r, '0);
                    check_eq("res_valid_o", 32'(res_valid), 32'd1);
                    check_eq("res_o.wb_en", 32'(res.wb_en), 32'd1);
                    check_eq("res_o.result", res.result,
                             alu_model(c == 0, 3'(f3), 1'(b30), a, b));
                end
            end
        end
        end_test("alu");
    endtask

    task automatic fwd_case(input reg_addr_t rs1, input reg_addr_t rs2, input logic fv,
                            input reg_addr_t frd);
        ex_req_t r;
        fwd_t    f;
        word_t   ea;
        word_t   eb;
        r           = '0;
        r.alu_class = CLS_REG_OP;
        r.rs1_addr  = rs1;
        r.rs2_addr  = rs2;
        r.rs1_data  = $urandom();
        r.rs2_data  = $urandom();
        r.rd_addr   = 5'd10;
        r.wb_en     = 1'b1;
        f.valid     = fv;
        f.rd        = frd;
        f.data      = $urandom();
        ea = (fv && frd == rs1 && rs1 != 5'd0) ? f.data : r.rs1_data;
        eb = (fv && frd == rs2 && rs2 != 5'd0) ? f.data : r.rs2_data;
        send(r, f);
        check_eq("res_o.result", res.result, ea + eb);
    endtask

    task automatic test_fwd();
        test_errs = n_errs;
        fwd_case(5'd5, 5'd6, 1'b1, 5'd5);
        fwd_case(5'd5, 5'd6, 1'b1, 5'd6);
        fwd_case(5'd5, 5'd5, 1'b1, 5'd5);
        fwd_case(5'd5, 5'd6, 1'b1, 5'd7);
        fwd_case(5'd5, 5'd6, 1'b0, 5'd5);
        fwd_case(5'd0, 5'd0, 1'b1, 5'd0);
        end_test("fwd");
    endtask

    task automatic test_branch();
        logic [2:0] conds [6];
        word_t      pa [3];
        word_t      pb [3];
        ex_req_t    r;
        word_t      pc;
        conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        pa    = '{32'd5, 32'hFFFF_FFFF, 32'd1};
        pb    = '{32'd5, 32'd1, 32'hFFFF_FFFF};
        test_errs = n_errs;
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < 3; i++) begin
                pc          = $urandom() & 32'hFFFF_FFFC;
                r           = '0;
                r.alu_class = CLS_BRANCH_SUB;
                r.branch    = 1'b1;
                r.funct3    = conds[k];
                r.pc        = pc;
                r.imm       = (i == 1) ? 32'hFFFF_FFF0 : 32'h0000_0040;
                r.rs1_addr  = 5'd1;
                r.rs1_data  = pa[i];
                r.rs2_addr  = 5'd2;
                r.rs2_data  = pb[i];
                send(r, '0);
                check_eq("res_o.taken", 32'(res.taken), 32'(branch_model(conds[k], pa[i], pb[i])));
                check_eq("res_o.target", res.target, pc + r.imm);
                check_eq("res_o.wb_en", 32'(res.wb_en), 32'd0);
            end
        end
        // jal
        pc        = $urandom() & 32'hFFFF_FFFC;
        r         = '0;
        r.jump    = JMP_JAL;
        r.op_src  = SRC_PC;
        r.use_imm = 1'b1;
        r.pc      = pc;
        r.imm     = 32'h0000_0800;
        r.rd_addr = 5'd1;
        r.wb_en   = 1'b1;
        send(r, '0);
        check_eq("res_o.taken", 32'(res.taken), 32'd1);
        check_eq("res_o.target", res.target, pc + 32'h0000_0800);
        check_eq("res_o.result", res.result, pc + 32'd4);
        // jalr with an odd sum
        r.jump     = JMP_JALR;
        r.op_src   = SRC_REG;
        r.imm      = 32'h0000_0013;
        r.rs1_addr = 5'd4;
        r.rs1_data = $urandom() & 32'hFFFF_FFFC;
        send(r, '0);
        check_eq("res_o.taken", 32'(res.taken), 32'd1);
        check_eq("res_o.target", res.target, (r.rs1_data + 32'h13) & 32'hFFFF_FFFE);
        check_eq("res_o.result", res.result, pc + 32'd4);
        end_test("branch");
    endtask

    task automatic test_mem();
        logic [2:0] kinds [5];
        fwd_t       f;
        word_t      addr;
        kinds = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        test_errs = n_errs;
        for (int i = 0; i < 4; i++) begin
            do_store(32'h100 + 32'(4 * i), 3'b010, $urandom(), '0);
        end
        do_store(32'h101, 3'b000, $urandom(), '0);
        do_store(32'h106, 3'b000, $urandom(), '0);
        do_store(32'h10B, 3'b000, $urandom(), '0);
        do_store(32'h10C, 3'b000, $urandom(), '0);
        do_store(32'h102, 3'b001, $urandom(), '0);
        do_store(32'h10A, 3'b001, $urandom(), '0);
        // store data taken from write-back
        f.valid = 1'b1;
        f.rd    = 5'd9;
        f.data  = $urandom();
        do_store(32'h110, 3'b010, $urandom(), f);
        for (int off = 0; off < 20; off++) begin
            addr = 32'h100 + 32'(off);
            case (kinds[off % 5])
                3'b001, 3'b101: addr = addr & 32'hFFFF_FFFE;
                3'b010:         addr = addr & 32'hFFFF_FFFC;
                default:        addr = addr;
            endcase
            do_load(addr, kinds[off % 5]);
        end
        end_test("mem");
    endtask

    task automatic test_mmio();
        word_t d;
        test_errs = n_errs;
        do_store(32'h14, 3'b010, $urandom(), '0);
        d = $urandom();
        mmio_store(32'h8000_0014, 3'b010, d, 4'b1111, d);
        d = $urandom();
        mmio_store(32'h8000_0003, 3'b000, d, 4'b1000, d << 24);
        do_load(32'h14, 3'b010);
        end_test("mmio");
    endtask

    task automatic test_csr_b2b();
        ex_req_t r;
        fwd_t    f;
        word_t   a;
        word_t   b;
        word_t   exp_q [$];
        test_errs  = n_errs;
        r          = '0;
        r.csr_we   = 1'b1;
        r.funct3   = 3'b001;
        r.rs1_addr = 5'd4;
        r.rs1_data = $urandom();
        r.imm      = 32'h0000_001F;
        f.valid    = 1'b1;
        f.rd       = 5'd4;
        f.data     = $urandom();
        send(r, f);
        check_eq("res_o.csr_we", 32'(res.csr_we), 32'd1);
        check_eq("res_o.csr_data", res.csr_data, f.data);
        r.funct3 = 3'b101;
        send(r, '0);
        check_eq("res_o.csr_data", res.csr_data, 32'h0000_001F);
        r.funct3 = 3'b010;
        send(r, '0);
        check_eq("res_o.csr_data", res.csr_data, 32'h0);
        // consecutive strobes, one result per cycle in order
        for (int i = 0; i < 8; i++) begin
            a           = $urandom();
            b           = $urandom();
            r           = '0;
            r.alu_class = CLS_REG_OP;
            r.funct3    = 3'b100;
            r.rs1_data  = a;
            r.rs2_data  = b;
            r.rd_addr   = 5'(i + 1);
            r.wb_en     = 1'b1;
            exp_q.push_back(a ^ b);
            req       = r;
            req_valid = 1'b1;
            @(negedge clk);
            check_eq("res_valid_o", 32'(res_valid), 32'd1);
            check_eq("res_o.rd", 32'(res.rd), 32'(i + 1));
            check_eq("res_o.result", res.result, exp_q.pop_front());
        end
        req_valid = 1'b0;
        @(negedge clk);
        check_eq("res_valid_o", 32'(res_valid), 32'd0);
        end_test("csr_b2b");
    endtask

    initial begin
        #(timeout_ns);
        $display("timeout: tests still running after %0d ns", timeout_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        req_valid = 1'b0;
        req       = '0;
        fwd       = '0;
        n_checks  = 0;
        n_errs    = 0;
        void'($urandom(43));
        @(posedge clk);
        wait (reset == 1'b0);
        @(negedge clk);
        test_alu();
        test_fwd();
        test_branch();
        test_mem();
        test_mmio();
        test_csr_b2b();
        $display("summary: %0d checks, %0d errors", n_checks, n_errs);
        if (n_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/rv_pkg.sv
hw/alu_unit.sv
hw/branch_unit.sv
hw/store_align.sv
hw/ex_stage.sv
hw/data_mem.sv
hw/ex_top.sv
sim/clk_gen.sv
sim/ex_chk.sv
sim/ex_tb.sv
